// ==== tb.f ====
hdl/mstore_pkg.sv
hdl/entry_decoder.sv
hdl/slot_store.sv
hdl/id_lookup.sv
hdl/matrix_store_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_matrix_store.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, status comes from the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_matrix_store -f tb.f \
    && ./obj_dir/Vtb_matrix_store | tee /dev/stderr | grep -q "^Testbench passed$" \
    || exit 1

// ==== verification/tb_matrix_store.sv ====
`default_nettype none

module tb_matrix_store;
    import mstore_pkg::*;

    localparam int NUM_TESTS  = 12;
    localparam int WAIT_LIMIT = 20;
    localparam int NO_BAD     = 255;     // No bad element in the entry
    localparam logic [7:0] BAD_ELEM = 8'd12;

    typedef struct packed {
        logic [95:0] name;
        logic [7:0]  rows;
        logic [7:0]  cols;
        logic [7:0]  n_elems;            // Elements sent before any flush
        logic        flush;
        logic [7:0]  bad_pos;
        logic        exp_err;
        logic        hold;               // Extra writes while done is high
        logic [7:0]  exp_id;
        logic [7:0]  rd_a;
        logic [7:0]  rd_b;
    } test_t;

    logic         clk;
    logic         rst;
    logic         wen;
    logic         flush;
    mode_e        mode;
    logic [7:0]   data;
    logic [7:0]   rd_a;
    logic [7:0]   rd_b;
    read_result_t mat_a;
    read_result_t mat_b;
    logic         input_done;
    logic         error;

    logic         check_req;
    logic         report_req;
    logic [95:0]  cur_name;
    logic         exp_err;
    logic         exp_done;
    read_result_t exp_a;
    read_result_t exp_b;
    int           fail_cnt;
    int           timeouts;
    logic [31:0]  lcg_state;
    test_t        tests [NUM_TESTS];

    // Reference model indexed by ID
    logic         mdl_valid [256];
    read_result_t mdl_mat   [256];

    tb_clock u_clock (.clk_o(clk), .rst_o(rst));

    matrix_store_top UUT (
        .clk          (clk),
        .rst          (rst),
        .wen_i        (wen),
        .flush_i      (flush),
        .mode_i       (mode),
        .data_i       (data),
        .read_id_a_i  (rd_a),
        .read_id_b_i  (rd_b),
        .mat_a_o      (mat_a),
        .mat_b_o      (mat_b),
        .input_done_o (input_done),
        .error_o      (error)
    );

    tb_checker u_checker (
        .clk_i (clk), .check_i (check_req), .report_i (report_req), .name_i (cur_name),
        .timeouts_i (timeouts), .exp_err_i (exp_err), .exp_done_i (exp_done),
        .exp_a_i (exp_a), .exp_b_i (exp_b), .error_i (error), .input_done_i (input_done),
        .mat_a_i (mat_a), .mat_b_i (mat_b), .fail_cnt_o (fail_cnt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic test_t make_test(input logic [95:0] name, input int rows, input int cols,
            input int n, input bit fl, input int bad, input bit err, input bit hold,
            input int id, input int ra, input int rb);
        return '{name, 8'(rows), 8'(cols), 8'(n), fl, 8'(bad), err, hold, 8'(id), 8'(ra), 8'(rb)};
    endfunction

    function automatic read_result_t expect_read(input logic [7:0] id);
        return (id != 8'd0 && mdl_valid[id]) ? mdl_mat[id] : '0;
    endfunction

    // ==================================================
    // Drive helpers
    // ==================================================
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic write_byte(input logic [7:0] b);
        wen  = 1'b1;
        data = b;
        next_cycle();
        wen  = 1'b0;
    endtask

    // Bounded wait for done or error to reach a level
    task automatic wait_flags(input test_t t, input logic level, input string what);
        int n;
        n = 0;
        while ((input_done || error) != level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if ((input_done || error) != level) begin
            $display("[FAIL] %0s: %0s", t.name, what);
            timeouts++;
        end
    endtask

    task automatic enter_matrix(input test_t t, output logic [MAT_W-1:0] sent);
        logic [7:0] elem;
        sent = '0;
        write_byte(t.rows);
        write_byte(t.cols);
        for (int k = 0; k < t.n_elems; k++) begin
            lcg_state = lcg_next(lcg_state);
            elem = (k == t.bad_pos) ? BAD_ELEM : 8'((lcg_state >> 16) % 32'd10);
            sent[k*8 +: 8] = elem;        // Row-major, unsent elements stay zero
            write_byte(elem);
        end
        if (t.flush) begin
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
        end
    endtask

    // Keeps at most two per type, oldest ID of the pair goes first
    task automatic model_commit(input test_t t, input logic [MAT_W-1:0] sent);
        int same;
        int oldest;
        same   = 0;
        oldest = 0;
        for (int id = 255; id >= 1; id--) begin
            if (mdl_valid[id] && mdl_mat[id].rows == 4'(t.rows)
                && mdl_mat[id].cols == 4'(t.cols)) begin
                same++;
                oldest = id;
            end
        end
        if (same >= MAX_PER_TYPE) mdl_valid[oldest] = 1'b0;
        mdl_valid[t.exp_id] = 1'b1;
        mdl_mat[t.exp_id]   = '{rows: 4'(t.rows), cols: 4'(t.cols), data: sent};
    endtask

    task automatic run_test(input test_t t);
        logic [MAT_W-1:0] sent;
        enter_matrix(t, sent);
        wait_flags(t, 1'b1, t.exp_err ? "error_o never rose" : "input_done_o never rose");
        if (t.hold) begin
            write_byte(8'd2);             // Would start a 2x2 entry if not ignored
            write_byte(8'd2);
            write_byte(8'd5);
            write_byte(8'd5);
        end
        if (!t.exp_err) model_commit(t, sent);
        rd_a = t.rd_a;
        rd_b = t.rd_b;
        repeat (3) next_cycle();
        cur_name  = t.name;
        exp_err   = t.exp_err;
        exp_done  = !t.exp_err;
        exp_a     = expect_read(t.rd_a);
        exp_b     = expect_read(t.rd_b);
        check_req = 1'b1;
        next_cycle();
        check_req = 0;
        mode = MODE_ACK0;
        wait_flags(t, 1'b0, "input_done_o or error_o stayed high after ACK");
        mode = MODE_INPUT;
    endtask

    // ==================================================
    // Stimulus table and main sequence
    // ==================================================
    initial begin
        int n;
        wen        = 1'b0;
        flush      = 1'b0;
        mode       = MODE_INPUT;
        data       = '0;
        rd_a       = '0;
        rd_b       = '0;
        check_req  = 1'b0;
        report_req = 1'b0;
        cur_name   = '0;
        exp_err    = 1'b0;
        exp_done   = 1'b0;
        exp_a      = '0;
        exp_b      = '0;
        timeouts   = 0;
        lcg_state  = 32'h92bb;
        for (int i = 0; i < 256; i++) mdl_valid[i] = 1'b0;

        //                    name          r  c  n  fl bad     err hold id rd_a rd_b
        tests[0]  = make_test("full_3x4",   3, 4, 12, 0, NO_BAD, 0, 0, 1, 1,   0);
        tests[1]  = make_test("flush_2x3",  2, 3, 4,  1, NO_BAD, 0, 0, 2, 2,   1);
        tests[2]  = make_test("bad_rows",   0, 3, 2,  0, NO_BAD, 1, 0, 0, 3,   2);
        tests[3]  = make_test("bad_cols",   2, 6, 0,  0, NO_BAD, 1, 0, 0, 3,   1);
        tests[4]  = make_test("bad_elem",   2, 2, 3,  0, 2,      1, 0, 0, 3,   2);
        tests[5]  = make_test("next_id",    1, 5, 5,  0, NO_BAD, 0, 0, 3, 3,   2);
        tests[6]  = make_test("pair_2x2_a", 2, 2, 4,  0, NO_BAD, 0, 0, 4, 4,   3);
        tests[7]  = make_test("pair_2x2_b", 2, 2, 4,  0, NO_BAD, 0, 0, 5, 5,   4);
        tests[8]  = make_test("pair_2x2_c", 2, 2, 4,  0, NO_BAD, 0, 0, 6, 4,   6);
        tests[9]  = make_test("dual_5x5",   5, 5, 25, 0, NO_BAD, 0, 0, 7, 5,   1);
        tests[10] = make_test("hold_1x1",   1, 1, 0,  1, NO_BAD, 0, 1, 8, 8,   200);
        tests[11] = make_test("after_hold", 1, 2, 2,  0, NO_BAD, 0, 0, 9, 9,   7);

        next_cycle();
        n = 0;
        while (rst && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (rst) begin
            $display("[FAIL] reset: rst never fell");
            timeouts++;
        end

        for (int i = 0; i < NUM_TESTS; i++) run_test(tests[i]);

        report_req = 1'b1;
        next_cycle();
        report_req = 1'b0;
        if (fail_cnt == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
`default_nettype none

module tb_checker (
    input  logic                      clk_i,
    input  logic                      check_i,      // Compare at the next falling edge
    input  logic                      report_i,
    input  logic [95:0]               name_i,
    input  int                        timeouts_i,
    input  logic                      exp_err_i,
    input  logic                      exp_done_i,
    input  mstore_pkg::read_result_t  exp_a_i,
    input  mstore_pkg::read_result_t  exp_b_i,
    input  logic                      error_i,
    input  logic                      input_done_i,
    input  mstore_pkg::read_result_t  mat_a_i,
    input  mstore_pkg::read_result_t  mat_b_i,
    output int                        fail_cnt_o
);
    import mstore_pkg::*;

    localparam int STAT_W = 2 + 2 * $bits(read_result_t);

    int                tests_run;
    int                tests_failed;
    logic [STAT_W-1:0] expected;
    logic [STAT_W-1:0] actual;

    // Status flags first, then port A, then port B
    assign expected = {exp_err_i, exp_done_i, exp_a_i, exp_b_i};
    assign actual   = {error_i, input_done_i, mat_a_i, mat_b_i};

    initial begin
        tests_run    = 0;
        tests_failed = 0;
    end

    always @(negedge clk_i) begin
        if (check_i) begin
            tests_run++;
            if (actual !== expected) begin
                tests_failed++;
                $display("[FAIL] %0s: expected %h, actual %h", name_i, expected, actual);
            end else begin
                $display("[PASS] %0s", name_i);
            end
        end
        if (report_i) begin
            $display("Tests run: %0d, failed: %0d, timeouts: %0d",
                     tests_run, tests_failed, timeouts_i);
        end
    end

    assign fail_cnt_o = tests_failed;

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release lines up with the stimulus drive point
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hdl/matrix_store_top.sv ====
`default_nettype none

module matrix_store_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wen_i,
    input  logic                            flush_i,
    input  mstore_pkg::mode_e               mode_i,
    input  logic [mstore_pkg::ELEM_W-1:0]   data_i,
    input  logic [mstore_pkg::ID_W-1:0]     read_id_a_i,
    input  logic [mstore_pkg::ID_W-1:0]     read_id_b_i,
    output mstore_pkg::read_result_t        mat_a_o,
    output mstore_pkg::read_result_t        mat_b_o,
    output logic                            input_done_o,
    output logic                            error_o
);
    import mstore_pkg::*;

    commit_t     commit;
    slot_table_t slot_table;

    // Decode byte stream into matrix commits
    entry_decoder u_entry_decoder (
        .clk          (clk),
        .rst          (rst),
        .wen_i        (wen_i),
        .flush_i      (flush_i),
        .mode_i       (mode_i),
        .data_i       (data_i),
        .commit_o     (commit),
        .input_done_o (input_done_o),
        .error_o      (error_o)
    );

    slot_store u_slot_store (
        .clk      (clk),
        .rst      (rst),
        .commit_i (commit),
        .table_o  (slot_table)
    );

    id_lookup u_id_lookup (
        .clk         (clk),
        .rst         (rst),
        .table_i     (slot_table),
        .read_id_a_i (read_id_a_i),
        .read_id_b_i (read_id_b_i),
        .mat_a_o     (mat_a_o),
        .mat_b_o     (mat_b_o)
    );

endmodule

`default_nettype wire

// ==== hdl/id_lookup.sv ====
`default_nettype none

module id_lookup (
    input  logic                             clk,
    input  logic                             rst,
    input  mstore_pkg::slot_table_t          table_i,
    input  logic [mstore_pkg::ID_W-1:0]      read_id_a_i,
    input  logic [mstore_pkg::ID_W-1:0]      read_id_b_i,
    output mstore_pkg::read_result_t         mat_a_o,
    output mstore_pkg::read_result_t         mat_b_o
);
    import mstore_pkg::*;

    typedef struct packed {
        logic      found;
        slot_idx_t idx;
    } match_t;

    match_t match_a_q;
    match_t match_b_q;

    // Highest matching index wins
    function automatic match_t find_slot(slot_table_t tbl, logic [ID_W-1:0] id);
        match_t m;
        m = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (tbl[i].used && tbl[i].id == id) begin
                m.found = 1'b1;
                m.idx   = slot_idx_t'(i);
            end
        end
        return m;
    endfunction

    function automatic read_result_t fetch(slot_table_t tbl, match_t m);
        read_result_t r;
        r = '0;                             // Unknown ID reads as zeros
        if (m.found) begin
            r.rows = tbl[m.idx].rows;
            r.cols = tbl[m.idx].cols;
            r.data = tbl[m.idx].data;
        end
        return r;
    endfunction

    // ==================================================
    // Stage 1 search, stage 2 data
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_a_q <= '0;
            match_b_q <= '0;
            mat_a_o   <= '0;
            mat_b_o   <= '0;
        end else begin
            match_a_q <= find_slot(table_i, read_id_a_i);
            match_b_q <= find_slot(table_i, read_id_b_i);
            mat_a_o   <= fetch(table_i, match_a_q);
            mat_b_o   <= fetch(table_i, match_b_q);
        end
    end

    a_port_a_found : assert property (@(posedge clk) disable iff (rst)
        (mat_a_o != '0) |-> $past(match_a_q.found));

    a_port_b_found : assert property (@(posedge clk) disable iff (rst)
        (mat_b_o != '0) |-> $past(match_b_q.found));

endmodule

`default_nettype wire

// ==== hdl/slot_store.sv ====
`default_nettype none

module slot_store (
    input  logic                    clk,
    input  logic                    rst,
    input  mstore_pkg::commit_t     commit_i,
    output mstore_pkg::slot_table_t table_o
);
    import mstore_pkg::*;

    // Control state
    logic [NUM_SLOTS-1:0] used_q;
    logic [AGE_W-1:0]     age_q [NUM_SLOTS];    // 0 is newest of its type
    logic [ID_W-1:0]      next_id_q;
    slot_idx_t            rr_ptr_q;

    // Payload
    logic [ID_W-1:0]  id_q   [NUM_SLOTS];
    dim_t             rows_q [NUM_SLOTS];
    dim_t             cols_q [NUM_SLOTS];
    logic [MAT_W-1:0] data_q [NUM_SLOTS];

    logic [NUM_SLOTS-1:0] same_type;
    logic [CNT_W-1:0]     same_cnt;
    logic                 free_found;
    logic                 old_found;
    slot_idx_t            free_idx;
    slot_idx_t            old_idx;
    slot_idx_t            wr_idx;
    logic                 use_rr;

    // ==================================================
    // Victim search
    // ==================================================
    always_comb begin
        same_cnt   = '0;
        free_found = 1'b0;
        free_idx   = '0;
        old_found  = 1'b0;
        old_idx    = '0;
        // Walk downwards so the lowest index wins
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            same_type[i] = used_q[i] && (rows_q[i] == commit_i.rows)
                           && (cols_q[i] == commit_i.cols);
            if (same_type[i]) begin
                same_cnt = same_cnt + 1'b1;
                if (age_q[i] == OLDEST_AGE) begin
                    old_found = 1'b1;
                    old_idx   = slot_idx_t'(i);
                end
            end
            if (!used_q[i]) begin
                free_found = 1'b1;
                free_idx   = slot_idx_t'(i);
            end
        end
    end

    always_comb begin
        use_rr = 1'b0;
        wr_idx = rr_ptr_q;
        if (same_cnt < CNT_W'(MAX_PER_TYPE)) begin
            if (free_found) begin
                wr_idx = free_idx;
            end else begin
                use_rr = 1'b1;              // Table full of other types
            end
        end else if (old_found) begin
            wr_idx = old_idx;               // Replace oldest of the pair
        end else begin
            use_rr = 1'b1;
        end
    end

    // ==================================================
    // Table update
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            used_q    <= '0;
            next_id_q <= ID_W'(1);
            rr_ptr_q  <= '0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                age_q[i] <= '0;
            end
        end else if (commit_i.valid) begin
            used_q[wr_idx] <= 1'b1;
            next_id_q      <= (next_id_q == '1) ? ID_W'(1) : next_id_q + 1'b1;
            if (use_rr) begin
                rr_ptr_q <= rr_ptr_q + 1'b1;
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (slot_idx_t'(i) == wr_idx) begin
                    age_q[i] <= '0;
                end else if (same_type[i] && age_q[i] != OLDEST_AGE) begin
                    age_q[i] <= age_q[i] + 1'b1;    // Saturates at oldest
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit_i.valid) begin
            id_q[wr_idx]   <= next_id_q;
            rows_q[wr_idx] <= commit_i.rows;
            cols_q[wr_idx] <= commit_i.cols;
            data_q[wr_idx] <= commit_i.data;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            table_o[i] = '{used: used_q[i], id: id_q[i], rows: rows_q[i],
                           cols: cols_q[i], data: data_q[i]};
        end
    end

    // Committed entry lands in the table with a real ID
    a_id_nonzero : assert property (@(posedge clk) disable iff (rst)
        commit_i.valid |=> table_o[$past(wr_idx)].used && table_o[$past(wr_idx)].id != '0);

endmodule

`default_nettype wire

// ==== hdl/entry_decoder.sv ====
`default_nettype none

module entry_decoder (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wen_i,
    input  logic                            flush_i,
    input  mstore_pkg::mode_e               mode_i,
    input  logic [mstore_pkg::ELEM_W-1:0]   data_i,
    output mstore_pkg::commit_t             commit_o,
    output logic                            input_done_o,
    output logic                            error_o
);
    import mstore_pkg::*;

    entry_state_e          state_q;
    dim_t                  rows_q;
    dim_t                  cols_q;
    logic [ELEM_CNT_W-1:0] elem_cnt_q;
    logic [MAT_W-1:0]      buf_q;        // Cleared at entry start
    logic [MAT_W-1:0]      buf_next;
    logic [7:0]            elem_total;
    logic                  last_elem;
    logic                  valid_q;
    logic                  done_q;
    logic                  err_q;

    logic is_ack;
    logic dim_ok;
    logic elem_ok;
    logic take_rows;
    logic take_cols;
    logic take_elem;

    // ==================================================
    // Input qualification
    // ==================================================
    assign is_ack  = (mode_i == MODE_ACK0) || (mode_i == MODE_ACK1);
    assign dim_ok  = (data_i >= ELEM_W'(1)) && (data_i <= ELEM_W'(MAX_DIM));
    assign elem_ok = (data_i <= ELEM_W'(MAX_ELEM_VAL));

    assign take_rows = (state_q == ST_IDLE) && wen_i && (mode_i == MODE_INPUT);
    assign take_cols = (state_q == ST_GET_N) && wen_i && (mode_i == MODE_INPUT);
    assign take_elem = (state_q == ST_GET_DATA) && !flush_i && wen_i && elem_ok;

    assign elem_total = 8'(rows_q) * 8'(cols_q);
    assign last_elem  = (8'(elem_cnt_q) == elem_total - 8'd1);

    // Current byte merged into the buffer
    always_comb begin
        buf_next = buf_q;
        buf_next[elem_cnt_q*ELEM_W +: ELEM_W] = data_i;
    end

    // ==================================================
    // Entry FSM
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            elem_cnt_q <= '0;
            valid_q    <= 1'b0;
            done_q     <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            valid_q <= 1'b0;               // Single-cycle strobe
            case (state_q)
                ST_IDLE: begin
                    if (take_rows) begin
                        if (dim_ok) begin
                            state_q <= ST_GET_N;
                        end else begin
                            err_q   <= 1'b1;
                            state_q <= ST_ERR;
                        end
                    end
                end
                ST_GET_N: begin
                    if (take_cols) begin
                        elem_cnt_q <= '0;
                        if (dim_ok) begin
                            state_q <= ST_GET_DATA;
                        end else begin
                            err_q   <= 1'b1;
                            state_q <= ST_ERR;
                        end
                    end
                end
                ST_GET_DATA: begin
                    if (flush_i) begin     // Early finish, rest stays zero
                        valid_q <= 1'b1;
                        done_q  <= 1'b1;
                        state_q <= ST_DONE;
                    end else if (wen_i) begin
                        if (!elem_ok) begin
                            err_q   <= 1'b1;
                            state_q <= ST_ERR;
                        end else if (last_elem) begin
                            valid_q <= 1'b1;
                            done_q  <= 1'b1;
                            state_q <= ST_DONE;
                        end else begin
                            elem_cnt_q <= elem_cnt_q + 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    if (is_ack) begin
                        done_q  <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                ST_ERR: begin
                    if (is_ack) begin
                        err_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Dimensions and element buffer
    always_ff @(posedge clk) begin
        if (take_rows) begin
            rows_q <= data_i[DIM_W-1:0];
            buf_q  <= '0;
        end
        if (take_cols) begin
            cols_q <= data_i[DIM_W-1:0];
        end
        if (take_elem) begin
            buf_q <= buf_next;
        end
    end

    assign commit_o     = '{valid: valid_q, rows: rows_q, cols: cols_q, data: buf_q};
    assign input_done_o = done_q;
    assign error_o      = err_q;

    // Store sees at most one commit per entry
    a_commit_pulse : assert property (@(posedge clk) disable iff (rst)
        commit_o.valid |=> !commit_o.valid);

endmodule

`default_nettype wire

// ==== hdl/mstore_pkg.sv ====
`default_nettype none

package mstore_pkg;

    // ==================================================
    // Limits and widths
    // ==================================================
    localparam int MAX_DIM      = 5;
    localparam int MAX_ELEMS    = MAX_DIM * MAX_DIM;     // 25 elements
    localparam int ELEM_W       = 8;
    localparam int MAX_ELEM_VAL = 9;
    localparam int NUM_SLOTS    = 16;
    localparam int MAX_PER_TYPE = 2;                     // Kept per rows x cols pair
    localparam int ID_W         = 8;                     // ID 0 means "none"
    localparam int MAT_W        = MAX_ELEMS * ELEM_W;    // 200 bits

    localparam int DIM_W      = 4;
    localparam int SLOT_W     = $clog2(NUM_SLOTS);
    localparam int ELEM_CNT_W = $clog2(MAX_ELEMS);
    localparam int CNT_W      = $clog2(NUM_SLOTS + 1);   // Same-type counter
    localparam int AGE_W      = $clog2(MAX_PER_TYPE);

    localparam logic [AGE_W-1:0] OLDEST_AGE = AGE_W'(MAX_PER_TYPE - 1);

    // ==================================================
    // Types
    // ==================================================
    typedef logic [DIM_W-1:0]  dim_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;

    typedef enum logic [1:0] {
        MODE_INPUT      = 2'b00,
        MODE_GEN_UNUSED = 2'b01,   // Generator removed, behaves as idle
        MODE_ACK0       = 2'b10,
        MODE_ACK1       = 2'b11
    } mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GET_N,
        ST_GET_DATA,
        ST_DONE,
        ST_ERR
    } entry_state_e;

    // Element k sits at bits 8k+7:8k
    typedef struct packed {
        logic             valid;
        dim_t             rows;
        dim_t             cols;
        logic [MAT_W-1:0] data;
    } commit_t;

    typedef struct packed {
        logic             used;
        logic [ID_W-1:0]  id;
        dim_t             rows;
        dim_t             cols;
        logic [MAT_W-1:0] data;
    } slot_t;

    typedef slot_t [NUM_SLOTS-1:0] slot_table_t;

    typedef struct packed {
        dim_t             rows;
        dim_t             cols;
        logic [MAT_W-1:0] data;
    } read_result_t;

endpackage

`default_nettype wire
